// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] data_val;
    typedef logic [4:0]      reg_addr;

    typedef enum logic [6:0]
    {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_L      = 7'b0000011,
        OPC_S      = 7'b0100011
    } opcode_t;

    // funct3 codes of the supported ALU operations.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed
    {
        logic [6:0] funct7;
        reg_addr    rs2;
        reg_addr    rs1;
        logic [2:0] funct3;
        reg_addr    rd;
    } r_type;

    typedef struct packed
    {
        logic [11:0] imm_11_0;
        reg_addr     rs1;
        logic [2:0]  funct3;
        reg_addr     rd;
    } i_type;

    typedef struct packed
    {
        logic [6:0] imm_11_5;
        reg_addr    rs2;
        reg_addr    rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
    } s_type;

    typedef struct packed
    {
        logic [19:0] imm_31_12;
        reg_addr     rd;
    } u_type;

    typedef union packed
    {
        r_type R;
        i_type I;
        s_type S;
        u_type U;
    } instr_body;

    typedef struct packed
    {
        instr_body body;
        opcode_t   opc;
    } instr;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    typedef enum logic {ALU_OPND_1_REG, ALU_OPND_1_PC} alu_opnd_1_sel;
    typedef enum logic {ALU_OPND_2_REG, ALU_OPND_2_IMM} alu_opnd_2_sel;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_optr;

    typedef struct packed
    {
        rv_isa_pkg::data_val opnd_1;
        rv_isa_pkg::data_val opnd_2;
        alu_optr             optr;
        logic                use_optr;
        rv_isa_pkg::data_val alt_out_val;
        logic                reg_wr_en;
        rv_isa_pkg::reg_addr reg_wr_addr;
        logic                mem_wr_en;
        logic                mem_rd_en;
        rv_isa_pkg::data_val mem_wr_val;
    } ex_ctrl;

    // result doubles as the byte address of loads and stores.
    typedef struct packed
    {
        rv_isa_pkg::data_val result;
        logic                reg_wr_en;
        rv_isa_pkg::reg_addr reg_wr_addr;
        logic                mem_wr_en;
        logic                mem_rd_en;
        rv_isa_pkg::data_val mem_wr_val;
    } mem_ctrl;

    typedef struct packed
    {
        logic                en;
        rv_isa_pkg::reg_addr addr;
        rv_isa_pkg::data_val val;
    } wb_port;

endpackage

// File: src/decode/decoder.sv
module decoder (
    input  rv_isa_pkg::instr          i_cur_instr,
    output pipe_pkg::alu_opnd_1_sel   o_opnd_1_sel,
    output pipe_pkg::alu_opnd_2_sel   o_opnd_2_sel,
    output pipe_pkg::alu_optr         o_optr,
    output logic                      o_use_optr,
    output logic                      o_reg_wr_en,
    output logic                      o_mem_wr_en,
    output logic                      o_mem_rd_en,
    output rv_isa_pkg::data_val       o_imm_val
);

    rv_isa_pkg::data_val imm_i, imm_s, imm_u;

    // shared by OP and OP-IMM, sub only set for OP.
    function automatic pipe_pkg::alu_optr f3_to_optr(input logic [2:0] funct3, input logic sub);
        pipe_pkg::alu_optr optr;
        case (funct3)
            rv_isa_pkg::F3_ADD: optr = sub ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLT: optr = pipe_pkg::ALU_SLT;
            rv_isa_pkg::F3_XOR: optr = pipe_pkg::ALU_XOR;
            rv_isa_pkg::F3_OR:  optr = pipe_pkg::ALU_OR;
            rv_isa_pkg::F3_AND: optr = pipe_pkg::ALU_AND;
            default:            optr = pipe_pkg::ALU_ADD;
        endcase
        return optr;
    endfunction

    assign imm_i = {{20{i_cur_instr.body.I.imm_11_0[11]}}, i_cur_instr.body.I.imm_11_0};
    assign imm_s = {{20{i_cur_instr.body.S.imm_11_5[6]}}, i_cur_instr.body.S.imm_11_5,
                    i_cur_instr.body.S.imm_4_0};
    assign imm_u = {i_cur_instr.body.U.imm_31_12, 12'b0};

    always_comb
    begin
        o_opnd_1_sel = pipe_pkg::ALU_OPND_1_REG;
        o_opnd_2_sel = pipe_pkg::ALU_OPND_2_IMM;
        o_optr       = pipe_pkg::ALU_ADD;
        o_use_optr   = 1'b1;
        o_reg_wr_en  = 1'b0;
        o_mem_wr_en  = 1'b0;
        o_mem_rd_en  = 1'b0;
        o_imm_val    = imm_i;

        case (i_cur_instr.opc)
            rv_isa_pkg::OPC_OP:
            begin
                o_opnd_2_sel = pipe_pkg::ALU_OPND_2_REG;
                o_optr       = f3_to_optr(i_cur_instr.body.R.funct3,
                                          i_cur_instr.body.R.funct7 == rv_isa_pkg::F7_SUB);
                o_reg_wr_en  = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM:
            begin
                o_optr      = f3_to_optr(i_cur_instr.body.I.funct3, 1'b0);
                o_reg_wr_en = 1'b1;
            end
            rv_isa_pkg::OPC_LUI:
            begin
                // result is taken from the immediate, alu bypassed.
                o_use_optr  = 1'b0;
                o_imm_val   = imm_u;
                o_reg_wr_en = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC:
            begin
                o_opnd_1_sel = pipe_pkg::ALU_OPND_1_PC;
                o_imm_val    = imm_u;
                o_reg_wr_en  = 1'b1;
            end
            rv_isa_pkg::OPC_L:
            begin
                o_mem_rd_en = 1'b1;
                o_reg_wr_en = 1'b1;
            end
            rv_isa_pkg::OPC_S:
            begin
                o_imm_val   = imm_s;
                o_mem_wr_en = 1'b1;
            end
            default:
            begin
                o_use_optr = 1'b0;
            end
        endcase

        // writes to x0 are dropped here.
        if (i_cur_instr.body.R.rd == '0)
            o_reg_wr_en = 1'b0;
    end

endmodule

// File: src/decode/regs.sv
module regs (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  rv_isa_pkg::reg_addr i_rd_addr_1,
    input  rv_isa_pkg::reg_addr i_rd_addr_2,
    input  pipe_pkg::wb_port    i_wr,
    output rv_isa_pkg::data_val o_val_1,
    output rv_isa_pkg::data_val o_val_2
);

    rv_isa_pkg::data_val rf [rv_isa_pkg::NUM_REGS];

    // x0 is never written, so it stays at its reset value of zero.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++)
                rf[i] <= '0;
        end
        else if (i_wr.en && (i_wr.addr != '0))
        begin
            rf[i_wr.addr] <= i_wr.val;
        end
    end

    assign o_val_1 = rf[i_rd_addr_1];
    assign o_val_2 = rf[i_rd_addr_2];

endmodule

// File: src/decode/pl1_decode.sv
module pl1_decode (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_instr_val,
    input  rv_isa_pkg::data_val i_pc,
    input  rv_isa_pkg::instr    i_cur_instr,
    input  pipe_pkg::wb_port    i_ff_1,
    input  pipe_pkg::wb_port    i_ff_2,
    input  pipe_pkg::wb_port    i_wb,
    output pipe_pkg::ex_ctrl    o_ex,
    output logic                o_stall
);

    rv_isa_pkg::reg_addr     rs1, rs2, rd;
    rv_isa_pkg::data_val     rf_val_1, rf_val_2, val_1, val_2, imm_val;
    pipe_pkg::alu_opnd_1_sel opnd_1_sel;
    pipe_pkg::alu_opnd_2_sel opnd_2_sel;
    pipe_pkg::alu_optr       optr;
    pipe_pkg::ex_ctrl        ex_next;
    logic                    use_optr, reg_wr_en, mem_wr_en, mem_rd_en;
    logic                    use_rs1, use_rs2, load_use, prev_stall;

    // youngest producer first, then the register file.
    function automatic rv_isa_pkg::data_val fwd(
        input rv_isa_pkg::reg_addr addr,
        input rv_isa_pkg::data_val rf_val,
        input pipe_pkg::wb_port    src_1,
        input pipe_pkg::wb_port    src_2,
        input pipe_pkg::wb_port    src_3
    );
        if (addr == '0)
            return '0;
        if (src_1.en && (src_1.addr == addr))
            return src_1.val;
        if (src_2.en && (src_2.addr == addr))
            return src_2.val;
        if (src_3.en && (src_3.addr == addr))
            return src_3.val;
        return rf_val;
    endfunction

    assign rs1 = i_cur_instr.body.R.rs1;
    assign rs2 = i_cur_instr.body.R.rs2;
    assign rd  = i_cur_instr.body.R.rd;

    decoder decoder_inst (
        .i_cur_instr  (i_cur_instr),
        .o_opnd_1_sel (opnd_1_sel),
        .o_opnd_2_sel (opnd_2_sel),
        .o_optr       (optr),
        .o_use_optr   (use_optr),
        .o_reg_wr_en  (reg_wr_en),
        .o_mem_wr_en  (mem_wr_en),
        .o_mem_rd_en  (mem_rd_en),
        .o_imm_val    (imm_val)
    );

    regs regs_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_1 (rs1),
        .i_rd_addr_2 (rs2),
        .i_wr        (i_wb),
        .o_val_1     (rf_val_1),
        .o_val_2     (rf_val_2)
    );

    assign val_1 = fwd(rs1, rf_val_1, i_ff_1, i_ff_2, i_wb);
    assign val_2 = fwd(rs2, rf_val_2, i_ff_1, i_ff_2, i_wb);

    // stores read rs2 for their data even though the alu takes the immediate.
    assign use_rs1 = (opnd_1_sel == pipe_pkg::ALU_OPND_1_REG) && use_optr;
    assign use_rs2 = (opnd_2_sel == pipe_pkg::ALU_OPND_2_REG) || mem_wr_en;

    // load sitting in the execute register has no data yet.
    assign load_use = o_ex.mem_rd_en && o_ex.reg_wr_en &&
                      ((use_rs1 && (o_ex.reg_wr_addr == rs1)) ||
                       (use_rs2 && (o_ex.reg_wr_addr == rs2)));

    assign o_stall = i_instr_val && load_use && !prev_stall;

    always_comb
    begin
        ex_next.opnd_1      = (opnd_1_sel == pipe_pkg::ALU_OPND_1_PC) ? i_pc : val_1;
        ex_next.opnd_2      = (opnd_2_sel == pipe_pkg::ALU_OPND_2_IMM) ? imm_val : val_2;
        ex_next.optr        = optr;
        ex_next.use_optr    = use_optr;
        ex_next.alt_out_val = imm_val;
        ex_next.reg_wr_en   = reg_wr_en;
        ex_next.reg_wr_addr = rd;
        ex_next.mem_wr_en   = mem_wr_en;
        ex_next.mem_rd_en   = mem_rd_en;
        ex_next.mem_wr_val  = val_2;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ex       <= '0;
            prev_stall <= 1'b0;
        end
        else
        begin
            prev_stall <= o_stall;
            // bubble on a stall or an empty slot.
            if (i_instr_val && !o_stall)
                o_ex <= ex_next;
            else
                o_ex <= '0;
        end
    end

endmodule

// File: src/pl2_execute.sv
module pl2_execute (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  pipe_pkg::ex_ctrl i_ex,
    output pipe_pkg::mem_ctrl o_mem,
    output pipe_pkg::wb_port o_ff
);

    rv_isa_pkg::data_val alu_out, result;
    logic                lt;

    assign lt = $signed(i_ex.opnd_1) < $signed(i_ex.opnd_2);

    always_comb
    begin
        case (i_ex.optr)
            pipe_pkg::ALU_ADD: alu_out = i_ex.opnd_1 + i_ex.opnd_2;
            pipe_pkg::ALU_SUB: alu_out = i_ex.opnd_1 - i_ex.opnd_2;
            pipe_pkg::ALU_AND: alu_out = i_ex.opnd_1 & i_ex.opnd_2;
            pipe_pkg::ALU_OR:  alu_out = i_ex.opnd_1 | i_ex.opnd_2;
            pipe_pkg::ALU_XOR: alu_out = i_ex.opnd_1 ^ i_ex.opnd_2;
            pipe_pkg::ALU_SLT: alu_out = rv_isa_pkg::data_val'(lt);
            default:           alu_out = i_ex.opnd_1 + i_ex.opnd_2;
        endcase
    end

    assign result = i_ex.use_optr ? alu_out : i_ex.alt_out_val;

    // forward to decode, a load has only its address here.
    assign o_ff.en   = i_ex.reg_wr_en && !i_ex.mem_rd_en;
    assign o_ff.addr = i_ex.reg_wr_addr;
    assign o_ff.val  = result;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_mem <= '0;
        end
        else
        begin
            o_mem.result      <= result;
            o_mem.reg_wr_en   <= i_ex.reg_wr_en;
            o_mem.reg_wr_addr <= i_ex.reg_wr_addr;
            o_mem.mem_wr_en   <= i_ex.mem_wr_en;
            o_mem.mem_rd_en   <= i_ex.mem_rd_en;
            o_mem.mem_wr_val  <= i_ex.mem_wr_val;
        end
    end

endmodule

// File: src/pl3_memory.sv
module pl3_memory (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  pipe_pkg::mem_ctrl i_mem,
    output pipe_pkg::wb_port  o_wb,
    output pipe_pkg::wb_port  o_ff
);

    rv_isa_pkg::data_val              ram [pipe_pkg::DMEM_WORDS] = '{default: '0};
    logic [pipe_pkg::DMEM_ADDR_W-1:0] word_addr;
    pipe_pkg::wb_port                 wb_next;

    // byte address, word aligned.
    assign word_addr = i_mem.result[pipe_pkg::DMEM_ADDR_W+1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_mem.mem_wr_en)
            ram[word_addr] <= i_mem.mem_wr_val;
    end

    assign wb_next.en   = i_mem.reg_wr_en;
    assign wb_next.addr = i_mem.reg_wr_addr;
    assign wb_next.val  = i_mem.mem_rd_en ? ram[word_addr] : i_mem.result;

    // load data is usable by decode already in this cycle.
    assign o_ff = wb_next;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_wb <= '0;
        else
            o_wb <= wb_next;
    end

endmodule

// File: src/pipe_top.sv
module pipe_top (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  rv_isa_pkg::instr    i_instr,
    input  rv_isa_pkg::data_val i_pc,
    input  logic                i_instr_val,
    output logic                o_stall,
    output pipe_pkg::wb_port    o_wb
);

    pipe_pkg::ex_ctrl  ex;
    pipe_pkg::mem_ctrl mem;
    // forwarding from execute and memory.
    pipe_pkg::wb_port  ff_1, ff_2;

    pl1_decode pl1_decode_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_instr_val (i_instr_val),
        .i_pc        (i_pc),
        .i_cur_instr (i_instr),
        .i_ff_1      (ff_1),
        .i_ff_2      (ff_2),
        .i_wb        (o_wb),
        .o_ex        (ex),
        .o_stall     (o_stall)
    );

    pl2_execute pl2_execute_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ex    (ex),
        .o_mem   (mem),
        .o_ff    (ff_1)
    );

    pl3_memory pl3_memory_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_mem   (mem),
        .o_wb    (o_wb),
        .o_ff    (ff_2)
    );

endmodule

// File: dv/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// rv32i opcodes of the supported subset.
localparam logic [6:0] OPC_R     = 7'b0110011;
localparam logic [6:0] OPC_I     = 7'b0010011;
localparam logic [6:0] OPC_LUI   = 7'b0110111;
localparam logic [6:0] OPC_AUIPC = 7'b0010111;
localparam logic [6:0] OPC_LOAD  = 7'b0000011;
localparam logic [6:0] OPC_STORE = 7'b0100011;

// architectural state, updated in program order.
logic [31:0] arch_regs [32] = '{default: '0};
logic [31:0] arch_mem [64]  = '{default: '0};

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic reads_rs1(input logic [31:0] ins);
    return (ins[6:0] == OPC_R) || (ins[6:0] == OPC_I) ||
           (ins[6:0] == OPC_LOAD) || (ins[6:0] == OPC_STORE);
endfunction

function automatic logic reads_rs2(input logic [31:0] ins);
    return (ins[6:0] == OPC_R) || (ins[6:0] == OPC_STORE);
endfunction

// runs one instruction on the architectural state and returns its register write.
function automatic pipe_pkg::wb_port ref_execute(input logic [31:0] ins, input logic [31:0] pc);
    pipe_pkg::wb_port wr;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      imm_i;
    logic [31:0]      imm_s;
    logic [31:0]      addr;

    a       = arch_regs[ins[19:15]];
    b       = arch_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    wr.en   = 1'b1;
    wr.addr = ins[11:7];
    wr.val  = '0;
    case (ins[6:0])
        OPC_R:     wr.val = alu_ref(ins[14:12], ins[31:25] == 7'b0100000, a, b);
        OPC_I:     wr.val = alu_ref(ins[14:12], 1'b0, a, imm_i);
        OPC_LUI:   wr.val = {ins[31:12], 12'b0};
        OPC_AUIPC: wr.val = pc + {ins[31:12], 12'b0};
        OPC_LOAD:
        begin
            addr   = a + imm_i;
            wr.val = arch_mem[addr[7:2]];
        end
        OPC_STORE:
        begin
            addr                = a + imm_s;
            arch_mem[addr[7:2]] = b;
            wr.en               = 1'b0;
        end
        default:   wr.en = 1'b0;
    endcase
    // x0 is hardwired to zero.
    if (wr.addr == '0)
        wr.en = 1'b0;
    if (wr.en)
        arch_regs[wr.addr] = wr.val;
    return wr;
endfunction

`endif

// File: dv/tb_pipe_top.sv
module tb_pipe_top;

    localparam int          CLK_PERIOD      = 40;
    localparam int          DRV_DLY         = 2;
    localparam int          RST_CYCLES      = 5;
    localparam int          NUM_INSTR       = 300;
    localparam int          WATCHDOG_CYCLES = NUM_INSTR * 2 + 20;
    localparam logic [31:0] SEED            = 32'h7f842893;

    logic                i_clk = 1'b0;
    logic                i_rst_n;
    rv_isa_pkg::instr    i_instr;
    rv_isa_pkg::data_val i_pc;
    logic                i_instr_val;
    logic                o_stall;
    pipe_pkg::wb_port    o_wb;

    pipe_pkg::wb_port    exp_q [$];
    logic                stall_last = 1'b0;

    `include "rv_ref_model.svh"

    pipe_top pipe_top_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_instr     (i_instr),
        .i_pc        (i_pc),
        .i_instr_val (i_instr_val),
        .o_stall     (o_stall),
        .o_wb        (o_wb)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // mostly x0..x4 so that dependencies and load-use pairs are common.
    function automatic logic [4:0] pick_reg();
        int r;
        r = int'($urandom % 8);
        if (r < 5)
            return 5'(r);
        return 5'(1 + $urandom % 30);
    endfunction

    function automatic logic [2:0] pick_f3();
        case ($urandom % 5)
            0:       return 3'b000;
            1:       return 3'b010;
            2:       return 3'b100;
            3:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] gen_instr();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] off;

        kind = int'($urandom % 16);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = pick_f3();
        f7   = ((f3 == 3'b000) && (($urandom % 2) == 1)) ? 7'b0100000 : 7'b0000000;
        // word offsets from the base of 64 in x31 span the whole data ram.
        off  = 12'(int'($urandom % 64) * 4 - 64);
        if (kind < 5)
            return {f7, rs2, rs1, f3, rd, OPC_R};
        if (kind < 9)
            return {12'($urandom), rs1, f3, rd, OPC_I};
        if (kind == 9)
            return {20'($urandom), rd, OPC_LUI};
        if (kind == 10)
            return {20'($urandom), rd, OPC_AUIPC};
        if (kind < 14)
            return {off, 5'd31, 3'b010, rd, OPC_LOAD};
        return {off[11:5], rs2, 5'd31, 3'b010, off[4:0], OPC_STORE};
    endfunction

    initial
    begin : stimulus
        logic [31:0]      cur;
        logic [31:0]      cur_pc;
        logic [4:0]       load_rd;
        logic             idle;
        logic             slot_val;
        logic             exp_stall;
        pipe_pkg::wb_port wr;
        int               n;

        void'($urandom(SEED));
        i_rst_n     = 1'b0;
        i_instr     = '0;
        i_pc        = '0;
        i_instr_val = 1'b0;
        cur_pc      = '0;
        load_rd     = '0;
        idle        = 1'b0;
        n           = 0;
        // addi x31, x0, 64 sets the base register of loads and stores.
        cur         = {12'd64, 5'd0, 3'b000, 5'd31, OPC_I};
        repeat (RST_CYCLES) @(posedge i_clk);
        #DRV_DLY;
        i_rst_n = 1'b1;
        compare_value("o_stall after reset", 32'(o_stall), 32'd0);
        compare_value("o_wb.en after reset", 32'(o_wb.en), 32'd0);
        while (n < NUM_INSTR)
        begin
            slot_val    = !idle;
            i_instr     = rv_isa_pkg::instr'(cur);
            i_pc        = cur_pc;
            i_instr_val = slot_val;
            @(negedge i_clk);
            // a load accepted at the last edge has no data for this instruction yet.
            exp_stall = slot_val && (load_rd != '0) &&
                        ((reads_rs1(cur) && (cur[19:15] == load_rd)) ||
                         (reads_rs2(cur) && (cur[24:20] == load_rd)));
            compare_value("o_stall", 32'(o_stall), 32'(exp_stall));
            load_rd = '0;
            if (slot_val && !exp_stall)
            begin
                wr = ref_execute(cur, cur_pc);
                if (wr.en)
                    exp_q.push_back(wr);
                if ((cur[6:0] == OPC_LOAD) && (cur[11:7] != '0))
                    load_rd = cur[11:7];
                cur_pc = cur_pc + 32'd4;
                n++;
                cur    = gen_instr();
                idle   = (($urandom % 16) == 0);
            end
            else
            begin
                idle = 1'b0;
            end
            @(posedge i_clk);
            #DRV_DLY;
        end
        i_instr_val = 1'b0;
        // the last writeback is sampled three negedges from here.
        repeat (4) @(posedge i_clk);
        if (exp_q.size() == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("%0d expected writebacks never appeared on o_wb", exp_q.size());
            abort_run();
        end
    end

    always @(negedge i_clk)
    begin : compare
        pipe_pkg::wb_port exp;

        if (i_rst_n)
        begin
            if (o_stall && stall_last)
            begin
                $display("o_stall stayed high for a second cycle in a row");
                abort_run();
            end
            else if (o_wb.en && (o_wb.addr == '0))
            begin
                $display("a write to x0 appeared on o_wb");
                abort_run();
            end
            else if (o_wb.en && (exp_q.size() == 0))
            begin
                $display("writeback to x%0d with no expected write pending", o_wb.addr);
                abort_run();
            end
            else
            begin
                stall_last = o_stall;
                if (o_wb.en)
                begin
                    exp = exp_q.pop_front();
                    compare_value("o_wb.addr", 32'(o_wb.addr), 32'(exp.addr));
                    compare_value("o_wb.val", o_wb.val, exp.val);
                end
            end
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("the run timed out after %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

// File: list.f
+incdir+dv
common/rv_isa_pkg.sv
common/pipe_pkg.sv
src/decode/decoder.sv
src/decode/regs.sv
src/decode/pl1_decode.sv
src/pl2_execute.sv
src/pl3_memory.sv
src/pipe_top.sv
dv/tb_pipe_top.sv

// File: build.sh
#!/bin/sh
# Builds the pipeline testbench with Verilator and runs it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_pipe_top -o sim_pipe
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_pipe
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
